// File: cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path and memory sizes
`define CPU_XLEN      32
`define CPU_MEM_DEPTH 2048
`define CPU_MEM_AW    11
`define CPU_REG_AW    5

// Instruction fields
`define CPU_OPC_MSB   31
`define CPU_OPC_LSB   27
`define CPU_RD_MSB    26
`define CPU_RD_LSB    22
`define CPU_RS0_MSB   21
`define CPU_RS0_LSB   17
`define CPU_RS1_MSB   16
`define CPU_RS1_LSB   12
`define CPU_IMM_W     22
`define CPU_FUNCT_W   3

`endif

// File: cpu_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

   typedef logic [`CPU_XLEN-1:0]   word_t;
   typedef logic [`CPU_REG_AW-1:0] reg_addr_t;
   typedef logic [`CPU_MEM_AW-1:0] mem_addr_t;

   typedef enum logic [2:0] {
      STAGE_IDLE       = 3'd0,
      STAGE_FETCH      = 3'd1,
      STAGE_MEM_READ   = 3'd2,
      STAGE_REG_UPDATE = 3'd3,
      STAGE_MEM_WRITE  = 3'd4,
      STAGE_PC_UPDATE  = 3'd5
   } stage_t;

   typedef enum logic [`CPU_OPC_MSB-`CPU_OPC_LSB:0] {
      OP_NOP   = 5'd0,
      OP_LOADI = 5'd1,
      OP_LOAD  = 5'd2,
      OP_STORE = 5'd3,
      OP_ALU   = 5'd4
   } opcode_t;

   // SHL/SHR use in1[4:0], SLT is unsigned
   typedef enum logic [`CPU_FUNCT_W-1:0] {
      ADD, SUB, AND, OR, XOR, SHL, SHR, SLT
   } alu_fn_t;

   typedef struct packed {
      opcode_t   op;
      reg_addr_t rd;
      reg_addr_t rs0;
      reg_addr_t rs1;
      word_t     imm;
      alu_fn_t   fn;
   } decoded_t;

   typedef struct packed {
      logic      en;
      reg_addr_t addr;
      word_t     data;
   } reg_write_t;

   typedef struct packed {
      logic      en;
      mem_addr_t addr;
      word_t     data;
   } mem_write_t;

endpackage

`default_nettype wire

// File: stage_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stage_sequencer (
   input  logic            clk,
   input  logic            rst,
   input  logic            run,
   output cpu_pkg::stage_t stage
);
   import cpu_pkg::*;

   stage_t stage_nxt;

   always_comb begin
      stage_nxt = stage;
      case (stage)
         STAGE_IDLE:       if (run) stage_nxt = STAGE_FETCH;
         STAGE_FETCH:      stage_nxt = STAGE_MEM_READ;
         STAGE_MEM_READ:   stage_nxt = STAGE_REG_UPDATE;
         STAGE_REG_UPDATE: stage_nxt = STAGE_MEM_WRITE;
         STAGE_MEM_WRITE:  stage_nxt = STAGE_PC_UPDATE;
         // Run is only looked at on an instruction boundary
         STAGE_PC_UPDATE:  stage_nxt = run ? STAGE_FETCH : STAGE_IDLE;
         default:          stage_nxt = STAGE_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         stage <= STAGE_IDLE;
      end else begin
         stage <= stage_nxt;
      end
   end

   a_stage_legal: assert property (@(posedge clk) disable iff (rst)
      stage inside {STAGE_IDLE, STAGE_FETCH, STAGE_MEM_READ, STAGE_REG_UPDATE,
                    STAGE_MEM_WRITE, STAGE_PC_UPDATE})
      else $error("stage left the legal set");

endmodule

`default_nettype wire

// File: decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module decoder (
   input  cpu_pkg::word_t    instr,
   output cpu_pkg::decoded_t decoded
);
   import cpu_pkg::*;

   logic [`CPU_OPC_MSB-`CPU_OPC_LSB:0] opc;

   assign opc = instr[`CPU_OPC_MSB:`CPU_OPC_LSB];

   always_comb begin
      // Unknown opcodes fall through as no-ops
      case (opc)
         OP_LOADI,
         OP_LOAD,
         OP_STORE,
         OP_ALU: begin
            decoded.op = opcode_t'(opc);
         end
         default: begin
            decoded.op = OP_NOP;
         end
      endcase

      decoded.rd  = instr[`CPU_RD_MSB:`CPU_RD_LSB];
      decoded.rs0 = instr[`CPU_RS0_MSB:`CPU_RS0_LSB];
      decoded.rs1 = instr[`CPU_RS1_MSB:`CPU_RS1_LSB];

      // Immediate overlaps rs0/rs1, zero extended
      decoded.imm = {{(`CPU_XLEN-`CPU_IMM_W){1'b0}}, instr[`CPU_IMM_W-1:0]};

      decoded.fn  = alu_fn_t'(instr[`CPU_FUNCT_W-1:0]);
   end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  cpu_pkg::word_t   in0,
   input  cpu_pkg::word_t   in1,
   input  cpu_pkg::alu_fn_t fn,
   output cpu_pkg::word_t   result
);
   import cpu_pkg::*;

   logic [4:0] shamt;

   assign shamt = in1[4:0];

   always_comb begin
      case (fn)
         ADD:     result = in0 + in1;
         SUB:     result = in0 - in1;
         AND:     result = in0 & in1;
         OR:      result = in0 | in1;
         XOR:     result = in0 ^ in1;
         SHL:     result = in0 << shamt;
         SHR:     result = in0 >> shamt;
         // Unsigned compare
         SLT:     result = word_t'(in0 < in1);
         default: result = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module register_file (
   input  logic                clk,
   input  cpu_pkg::reg_addr_t  raddr0,
   input  cpu_pkg::reg_addr_t  raddr1,
   output cpu_pkg::word_t      rdata0,
   output cpu_pkg::word_t      rdata1,
   input  cpu_pkg::reg_write_t wr
);
   import cpu_pkg::*;

   localparam int NUM_REGS = 2 ** `CPU_REG_AW;

   word_t regs [NUM_REGS];

   assign rdata0 = regs[raddr0];
   assign rdata1 = regs[raddr1];

   always_ff @(posedge clk) begin
      if (wr.en) begin
         regs[wr.addr] <= wr.data;
      end
   end

   a_wr_addr_known: assert property (@(posedge clk)
      wr.en |-> !$isunknown(wr.addr))
      else $error("register write with unknown address");

endmodule

`default_nettype wire

// File: register_file_control.sv
`timescale 1ns/1ps
`default_nettype none

module register_file_control (
   input  cpu_pkg::stage_t     stage,
   input  cpu_pkg::decoded_t   decoded,
   input  cpu_pkg::word_t      mem_rdata,
   input  cpu_pkg::word_t      alu_result,
   output cpu_pkg::reg_addr_t  raddr0,
   output cpu_pkg::reg_addr_t  raddr1,
   output cpu_pkg::reg_write_t wr
);
   import cpu_pkg::*;

   logic writes_reg;

   // Operands are always read from rs0 and rs1
   assign raddr0 = decoded.rs0;
   assign raddr1 = decoded.rs1;

   assign writes_reg = decoded.op inside {OP_LOADI, OP_LOAD, OP_ALU};

   always_comb begin
      wr.en   = (stage == STAGE_REG_UPDATE) && writes_reg;
      wr.addr = decoded.rd;

      // Write source by instruction type
      case (decoded.op)
         OP_LOADI: begin
            wr.data = decoded.imm;
         end
         OP_LOAD: begin
            wr.data = mem_rdata;
         end
         default: begin
            wr.data = alu_result;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: main_memory_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module main_memory_control (
   input  cpu_pkg::stage_t     stage,
   input  cpu_pkg::word_t      pc,
   input  cpu_pkg::decoded_t   decoded,
   input  cpu_pkg::word_t      rdata0,
   input  cpu_pkg::word_t      rdata1,
   input  cpu_pkg::mem_write_t load,
   output cpu_pkg::mem_addr_t  raddr,
   output cpu_pkg::mem_write_t wr
);
   import cpu_pkg::*;

   // Fetch from PC, data accesses through rs0
   assign raddr = (stage == STAGE_FETCH) ? pc[`CPU_MEM_AW-1:0] : rdata0[`CPU_MEM_AW-1:0];

   always_comb begin
      if (stage == STAGE_IDLE) begin
         // External loader owns the port while halted
         wr = load;
      end else begin
         wr.en   = (stage == STAGE_MEM_WRITE) && (decoded.op == OP_STORE);
         wr.addr = rdata0[`CPU_MEM_AW-1:0];
         wr.data = rdata1;
      end
   end

   a_wr_stage: assert final (!wr.en || stage inside {STAGE_MEM_WRITE, STAGE_IDLE})
      else $error("memory write outside MEM_WRITE or IDLE");

endmodule

`default_nettype wire

// File: main_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module main_memory (
   input  logic                clk,
   input  cpu_pkg::mem_addr_t  raddr,
   output cpu_pkg::word_t      rdata,
   input  cpu_pkg::mem_write_t wr
);
   import cpu_pkg::*;

   // Word addressed, one word per instruction
   word_t mem [`CPU_MEM_DEPTH];

   initial begin
      for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // Combinational read
   assign rdata = mem[raddr];

   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

endmodule

`default_nettype wire

// File: cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu (
   input  logic                clk,
   input  logic                rst,
   input  logic                run,
   input  cpu_pkg::mem_write_t load,
   output cpu_pkg::word_t      pc,
   output cpu_pkg::reg_write_t rf_wr,
   output cpu_pkg::mem_write_t mem_wr
);
   import cpu_pkg::*;

   stage_t     stage;
   decoded_t   decoded;
   word_t      instr_q;
   word_t      pc_q;
   word_t      mem_rdata;
   mem_addr_t  mem_raddr;
   reg_addr_t  rf_raddr0;
   reg_addr_t  rf_raddr1;
   word_t      rf_rdata0;
   word_t      rf_rdata1;
   word_t      alu_in0;
   word_t      alu_in1;
   alu_fn_t    alu_fn;
   word_t      alu_result;

   stage_sequencer stage_seq_i (
      .clk   (clk),
      .rst   (rst),
      .run   (run),
      .stage (stage)
   );

   // Instruction register and PC
   always_ff @(posedge clk) begin
      if (rst) begin
         instr_q <= '0;
         pc_q    <= '0;
      end else begin
         if (stage == STAGE_FETCH) begin
            instr_q <= mem_rdata;
         end
         if (stage == STAGE_PC_UPDATE) begin
            // Wrap at memory depth
            pc_q <= word_t'(alu_result[`CPU_MEM_AW-1:0]);
         end
      end
   end

   decoder decoder_i (
      .instr   (instr_q),
      .decoded (decoded)
   );

   // ALU is shared with the PC increment
   always_comb begin
      if (stage == STAGE_PC_UPDATE) begin
         alu_in0 = pc_q;
         alu_in1 = word_t'(1);
         alu_fn  = ADD;
      end else begin
         alu_in0 = rf_rdata0;
         alu_in1 = rf_rdata1;
         alu_fn  = decoded.fn;
      end
   end

   alu alu_i (
      .in0    (alu_in0),
      .in1    (alu_in1),
      .fn     (alu_fn),
      .result (alu_result)
   );

   register_file_control rf_ctrl_i (
      .stage      (stage),
      .decoded    (decoded),
      .mem_rdata  (mem_rdata),
      .alu_result (alu_result),
      .raddr0     (rf_raddr0),
      .raddr1     (rf_raddr1),
      .wr         (rf_wr)
   );

   register_file rf_i (
      .clk    (clk),
      .raddr0 (rf_raddr0),
      .raddr1 (rf_raddr1),
      .rdata0 (rf_rdata0),
      .rdata1 (rf_rdata1),
      .wr     (rf_wr)
   );

   main_memory_control mem_ctrl_i (
      .stage   (stage),
      .pc      (pc_q),
      .decoded (decoded),
      .rdata0  (rf_rdata0),
      .rdata1  (rf_rdata1),
      .load    (load),
      .raddr   (mem_raddr),
      .wr      (mem_wr)
   );

   main_memory mem_i (
      .clk   (clk),
      .raddr (mem_raddr),
      .rdata (mem_rdata),
      .wr    (mem_wr)
   );

   assign pc = pc_q;

endmodule

`default_nettype wire

// File: tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu;
   import cpu_pkg::*;

   localparam int TOTAL_INSTR = 263;
   // Five cycles per instruction plus one loader cycle per program word
   localparam int CYCLE_LIMIT = TOTAL_INSTR * 5 + TOTAL_INSTR + 200;

   logic       clk;
   logic       rst;
   logic       run;
   mem_write_t load;
   word_t      pc;
   reg_write_t rf_wr;
   mem_write_t mem_wr;

   integer     seed;
   int         errors;
   int         tests_run;
   int         tests_failed;
   int         errors_at_start;
   int         cycle_count;
   int         phase;
   word_t      last_pc;
   logic       loading;
   int         prog_addr;
   int         ref_pc;

   word_t      ref_regs [32];
   word_t      ref_mem [`CPU_MEM_DEPTH];
   word_t      prog [$];
   reg_write_t exp_rf [$];
   mem_write_t exp_mem [$];

   cpu cpu_i (
      .clk    (clk),
      .rst    (rst),
      .run    (run),
      .load   (load),
      .pc     (pc),
      .rf_wr  (rf_wr),
      .mem_wr (mem_wr)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the core stopped making progress", cycle_count);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic report_failure(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      errors++;
   endtask

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic word_t encode(input logic [4:0] op, input int unsigned rd,
                                    input int unsigned rs0, input int unsigned rs1,
                                    input int unsigned fn);
      word_t w;
      w = '0;
      w[`CPU_OPC_MSB:`CPU_OPC_LSB] = op;
      w[`CPU_RD_MSB:`CPU_RD_LSB]   = rd[4:0];
      w[`CPU_RS0_MSB:`CPU_RS0_LSB] = rs0[4:0];
      w[`CPU_RS1_MSB:`CPU_RS1_LSB] = rs1[4:0];
      w[`CPU_FUNCT_W-1:0]          = fn[2:0];
      return w;
   endfunction

   function automatic word_t encode_loadi(input int unsigned rd, input int unsigned imm);
      word_t w;
      w = encode(OP_LOADI, rd, 0, 0, 0);
      w[`CPU_IMM_W-1:0] = imm[`CPU_IMM_W-1:0];
      return w;
   endfunction

   function automatic int unsigned rand_imm();
      return rand_below(32'd1 << `CPU_IMM_W);
   endfunction

   function automatic word_t alu_model(input logic [2:0] fn, input word_t a, input word_t b);
      case (fn)
         ADD:     return a + b;
         SUB:     return a - b;
         AND:     return a & b;
         OR:      return a | b;
         XOR:     return a ^ b;
         SHL:     return a << b[4:0];
         SHR:     return a >> b[4:0];
         default: return (a < b) ? 32'd1 : 32'd0;
      endcase
   endfunction

   // Executes one instruction on the model state and returns the expected writes
   function automatic void ref_exec(input word_t instr, output reg_write_t rf,
                                    output mem_write_t mw);
      logic [4:0] op;
      word_t      a;
      word_t      b;
      op = instr[`CPU_OPC_MSB:`CPU_OPC_LSB];
      a  = ref_regs[instr[`CPU_RS0_MSB:`CPU_RS0_LSB]];
      b  = ref_regs[instr[`CPU_RS1_MSB:`CPU_RS1_LSB]];
      rf = '0;
      mw = '0;
      rf.addr = instr[`CPU_RD_MSB:`CPU_RD_LSB];
      case (op)
         OP_LOADI: begin
            rf.en   = 1'b1;
            rf.data = word_t'(instr[`CPU_IMM_W-1:0]);
         end
         OP_LOAD: begin
            rf.en   = 1'b1;
            rf.data = ref_mem[a[`CPU_MEM_AW-1:0]];
         end
         OP_STORE: begin
            mw.en   = 1'b1;
            mw.addr = a[`CPU_MEM_AW-1:0];
            mw.data = b;
         end
         OP_ALU: begin
            rf.en   = 1'b1;
            rf.data = alu_model(instr[`CPU_FUNCT_W-1:0], a, b);
         end
         default: begin
         end
      endcase
      if (rf.en) ref_regs[rf.addr] = rf.data;
      if (mw.en) ref_mem[mw.addr] = mw.data;
   endfunction

   // Trace checker, samples the write buses mid-cycle
   always @(negedge clk) begin : trace_check
      reg_write_t rf_exp;
      mem_write_t mem_exp;
      if (!rst) begin
         if (pc !== last_pc) begin
            phase   = 0;
            last_pc = pc;
         end else begin
            phase = phase + 1;
         end
         if (rf_wr.en === 1'b1) begin
            if (phase != 2) report_failure("register write outside the register update cycle");
            if (exp_rf.size() == 0) begin
               report_failure($sformatf("unexpected register write to r%0d", rf_wr.addr));
            end else begin
               rf_exp = exp_rf.pop_front();
               if (rf_wr !== rf_exp) begin
                  report_mismatch($sformatf("register write r%0d=%h, expected r%0d=%h",
                                            rf_wr.addr, rf_wr.data, rf_exp.addr, rf_exp.data));
               end
            end
         end
         if (mem_wr.en === 1'b1 && !loading) begin
            if (phase != 3) report_failure("memory write outside the memory write cycle");
            if (exp_mem.size() == 0) begin
               report_failure($sformatf("unexpected memory write to %0d", mem_wr.addr));
            end else begin
               mem_exp = exp_mem.pop_front();
               if (mem_wr !== mem_exp) begin
                  report_mismatch($sformatf("memory write [%0d]=%h, expected [%0d]=%h",
                                            mem_wr.addr, mem_wr.data, mem_exp.addr, mem_exp.data));
               end
            end
         end
      end
   end

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic load_program();
      loading = 1'b1;
      foreach (prog[i]) begin
         load.en   = 1'b1;
         load.addr = mem_addr_t'(prog_addr);
         load.data = prog[i];
         ref_mem[prog_addr] = prog[i];
         prog_addr = (prog_addr + 1) % `CPU_MEM_DEPTH;
         @(negedge clk);
         if (mem_wr !== load) begin
            report_mismatch($sformatf("loader write shows %h, expected %h", mem_wr, load));
         end
         step();
      end
      load    = '0;
      loading = 1'b0;
   endtask

   // Loads the program at the held PC, runs it and halts after its last instruction
   task automatic execute_program();
      int         n;
      int         cycles;
      word_t      prev_pc;
      reg_write_t rf;
      mem_write_t mw;
      n = prog.size();
      load_program();
      prog.delete();
      if (pc !== word_t'(ref_pc)) begin
         report_mismatch($sformatf("held PC is %0d, expected %0d", pc, ref_pc));
      end
      for (int i = 0; i < n; i++) begin
         ref_exec(ref_mem[ref_pc], rf, mw);
         if (rf.en) exp_rf.push_back(rf);
         if (mw.en) exp_mem.push_back(mw);
         ref_pc = (ref_pc + 1) % `CPU_MEM_DEPTH;
      end
      prev_pc = pc;
      phase   = -2;
      run     = 1'b1;
      step();
      if (n == 1) run = 1'b0;
      for (int k = 1; k <= n; k++) begin
         cycles = 0;
         while (pc === prev_pc && cycles < 8) begin
            step();
            cycles++;
         end
         if (cycles != 5) begin
            report_failure($sformatf("instruction %0d took %0d cycles instead of five", k, cycles));
         end
         if (pc !== word_t'((prev_pc + 1) % `CPU_MEM_DEPTH)) begin
            report_mismatch($sformatf("PC is %0d, expected %0d", pc, prev_pc + 1));
         end
         prev_pc = pc;
         if (k == n - 1) run = 1'b0;
      end
      if (exp_rf.size() != 0 || exp_mem.size() != 0) begin
         report_failure($sformatf("%0d register and %0d memory writes never appeared",
                                  exp_rf.size(), exp_mem.size()));
      end
      exp_rf.delete();
      exp_mem.delete();
   endtask

   task automatic hold_idle(input int cycles);
      word_t held;
      held = pc;
      repeat (cycles) begin
         step();
         if (pc !== held) report_mismatch($sformatf("PC moved to %0d while halted", pc));
      end
   endtask

   task automatic start_test();
      errors_at_start = errors;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == errors_at_start) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
         tests_failed++;
      end
   endtask

   initial begin
      seed         = 32'h1b67_7557;
      clk          = 1'b0;
      rst          = 1'b1;
      run          = 1'b0;
      load         = '0;
      loading      = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      cycle_count  = 0;
      phase        = 0;
      last_pc      = '0;
      prog_addr    = 0;
      ref_pc       = 0;
      foreach (ref_regs[i]) ref_regs[i] = '0;
      foreach (ref_mem[i]) ref_mem[i] = '0;

      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      if (pc !== '0 || rf_wr.en !== 1'b0 || mem_wr.en !== 1'b0) begin
         report_failure("core did not leave reset idle with PC 0 and no writes");
      end

      start_test();
      for (int r = 0; r < 8; r++) prog.push_back(encode_loadi(r, rand_imm()));
      for (int i = 0; i < 4; i++) prog.push_back(encode_loadi(8 + rand_below(24), rand_imm()));
      execute_program();
      finish_test("load immediate");

      start_test();
      for (int r = 0; r < 8; r++) prog.push_back(encode_loadi(r, rand_imm()));
      for (int f = 0; f < 16; f++) begin
         prog.push_back(encode(OP_ALU, 8 + rand_below(24), rand_below(8), rand_below(8), f % 8));
      end
      execute_program();
      finish_test("alu functions");

      start_test();
      prog.push_back(encode_loadi(6, 1500));
      prog.push_back(encode_loadi(7, 1100));
      prog.push_back(encode_loadi(1, rand_imm()));
      prog.push_back(encode_loadi(2, rand_imm()));
      prog.push_back(encode(OP_ALU, 3, 1, 2, SUB));
      prog.push_back(encode(OP_STORE, 0, 6, 3, 0));
      prog.push_back(encode(OP_STORE, 0, 7, 1, 0));
      prog.push_back(encode(OP_LOAD, 4, 6, 0, 0));
      prog.push_back(encode(OP_LOAD, 5, 7, 0, 0));
      prog.push_back(encode(OP_STORE, 0, 7, 4, 0));
      prog.push_back(encode(OP_LOAD, 8, 7, 0, 0));
      execute_program();
      finish_test("store then load");

      start_test();
      for (int i = 0; i < 4; i++) begin
         prog.push_back(encode(OP_NOP, rand_below(32), rand_below(32), rand_below(32), rand_below(8)));
      end
      for (int i = 0; i < 6; i++) begin
         prog.push_back(encode(5 + rand_below(27), rand_below(32), rand_below(32), rand_below(32),
                               rand_below(8)));
      end
      execute_program();
      finish_test("nop and unknown opcodes");

      start_test();
      prog.push_back(encode_loadi(10, rand_imm()));
      prog.push_back(encode_loadi(11, rand_imm()));
      prog.push_back(encode(OP_NOP, 0, 0, 0, 0));
      execute_program();
      hold_idle(6);
      // Second half is loaded while halted and resumes at the held PC
      prog.push_back(encode(OP_ALU, 12, 10, 11, ADD));
      prog.push_back(encode(OP_STORE, 0, 6, 12, 0));
      prog.push_back(encode(OP_LOAD, 13, 6, 0, 0));
      execute_program();
      finish_test("run and idle");

      start_test();
      for (int r = 0; r < 6; r++) prog.push_back(encode_loadi(r, rand_imm()));
      prog.push_back(encode_loadi(6, 1024 + rand_below(1024)));
      prog.push_back(encode_loadi(7, 1024 + rand_below(1024)));
      for (int i = 0; i < 192; i++) begin
         case (rand_below(5))
            0: prog.push_back(encode(OP_NOP, 0, 0, 0, 0));
            1: prog.push_back(encode_loadi(rand_below(6), rand_imm()));
            2: prog.push_back(encode(OP_LOAD, rand_below(6), 6 + rand_below(2), 0, 0));
            3: prog.push_back(encode(OP_STORE, 0, 6 + rand_below(2), rand_below(8), 0));
            default: prog.push_back(encode(OP_ALU, rand_below(6), rand_below(8), rand_below(8),
                                           rand_below(8)));
         endcase
      end
      execute_program();
      finish_test("random program");

      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
cpu_pkg.sv
stage_sequencer.sv
decoder.sv
alu.sv
register_file.sv
register_file_control.sv
main_memory_control.sv
main_memory.sv
cpu.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - stage_sequencer.sv
      - decoder.sv
      - alu.sv
      - register_file.sv
      - register_file_control.sv
      - main_memory_control.sv
      - main_memory.sv
      - cpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu.sv
